//--- design/acc_params.svh
/* accumulator harness parameters
   address width, memory sizing, boot address and magic peripheral addresses */
`ifndef ACC_PARAMS_SVH
`define ACC_PARAMS_SVH

// byte address width shared by the core, the FIFOs and the memory
`define ACC_ADDR_W 16

// word RAM occupying bytes 0x0000 to 0x0FFF
`define ACC_RAM_WORDS 1024

// entries in each request FIFO between core and memory
`define ACC_FIFO_DEPTH 4

// program counter value after reset
`define ACC_BOOT_ADDR 16'h0000

// stores to these addresses drive the pass, fail and exit outputs
`define ACC_PASS_ADDR 16'h8000
`define ACC_FAIL_ADDR 16'h8004
`define ACC_EXIT_ADDR 16'h8008

`endif

//--- design/acc_pkg.sv
/* accumulator harness types
   opcode encoding and the request payloads carried on the memory ports */
`include "acc_params.svh"

package acc_pkg;

    // opcode field of an instruction word, bits 31 to 28
    // code 0 is left unassigned so that cleared memory decodes as a no-op
    typedef enum logic [3:0] {
        OP_LDI  = 4'h1,
        OP_ADDI = 4'h2,
        OP_LD   = 4'h3,
        OP_ADD  = 4'h4,
        OP_ST   = 4'h5,
        OP_BNZ  = 4'h6,
        OP_JMP  = 4'h7
    } acc_op_e;

    // instruction fetch request, a read of one word
    typedef struct packed {
        logic [`ACC_ADDR_W-1:0] addr;
    } ifetch_req_t;

    // data request, a load when we is low and a store when it is high
    typedef struct packed {
        logic [`ACC_ADDR_W-1:0] addr;
        logic                   we;
        logic [31:0]            wdata;
    } data_req_t;

endpackage

//--- design/mem_port_if.sv
/* memory port with req/gnt/rvalid handshake
   the request payload type is chosen per instance */
`timescale 1ns/100ps

interface mem_port_if #(
    parameter type req_t = logic
);

    logic        req;
    logic        gnt;
    req_t        payload;
    logic        rvalid;
    logic [31:0] rdata;

    // requester side, holds req and payload until gnt
    modport core (
        output req,
        output payload,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    // responder side, returns read data one rvalid pulse per read
    modport mem (
        input  req,
        input  payload,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

//--- design/acc_core.sv
/* accumulator core
   fetches one instruction at a time, executes it and issues loads and posted stores */
`timescale 1ns/100ps
`include "acc_params.svh"

module acc_core import acc_pkg::*; (
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  logic    fetch_enable_i,
    mem_port_if.core if_ins,
    mem_port_if.core if_dat
);

    localparam int AW = `ACC_ADDR_W;

    typedef enum logic [2:0] {
        FETCH,
        WAIT_INSTR,
        EXEC,
        DATA_REQ,
        WAIT_DATA
    } state_e;

    state_e      state_q;
    logic [AW-1:0] pc_q;
    logic [AW-1:0] pc_inc;
    logic [31:0] acc_q;
    logic [31:0] instr_q;
    acc_op_e     op;
    logic [AW-1:0] target;
    logic [31:0] imm_zext;
    logic [31:0] imm_sext;
    ifetch_req_t ins_req;
    data_req_t   dat_req;

    // decode fields of the latched instruction word
    assign op       = acc_op_e'(instr_q[31:28]);
    assign target   = instr_q[AW-1:0];
    assign imm_zext = {16'h0000, instr_q[15:0]};
    assign imm_sext = {{16{instr_q[15]}}, instr_q[15:0]};
    assign pc_inc   = pc_q + AW'(4);

    // the fetch request stays up in FETCH until the instruction FIFO accepts it
    assign ins_req.addr   = pc_q;
    assign if_ins.req     = (state_q == FETCH) && fetch_enable_i;
    assign if_ins.payload = ins_req;

    assign dat_req.addr   = target;
    assign dat_req.we     = (op == OP_ST);
    assign dat_req.wdata  = acc_q;
    assign if_dat.req     = (state_q == DATA_REQ);
    assign if_dat.payload = dat_req;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= FETCH;
            pc_q    <= AW'(`ACC_BOOT_ADDR);
            acc_q   <= '0;
        end else begin
            case (state_q)
                FETCH: begin
                    if (if_ins.req && if_ins.gnt) begin
                        state_q <= WAIT_INSTR;
                    end
                end
                WAIT_INSTR: begin
                    if (if_ins.rvalid) begin
                        state_q <= EXEC;
                    end
                end
                EXEC: begin
                    case (op)
                        OP_LDI: begin
                            acc_q   <= imm_zext;
                            pc_q    <= pc_inc;
                            state_q <= FETCH;
                        end
                        OP_ADDI: begin
                            acc_q   <= acc_q + imm_sext;
                            pc_q    <= pc_inc;
                            state_q <= FETCH;
                        end
                        OP_LD, OP_ADD, OP_ST: begin
                            state_q <= DATA_REQ;
                        end
                        OP_BNZ: begin
                            pc_q    <= (acc_q != '0) ? target : pc_inc;
                            state_q <= FETCH;
                        end
                        OP_JMP: begin
                            pc_q    <= target;
                            state_q <= FETCH;
                        end
                        default: begin
                            // unassigned opcodes fall through as no-ops
                            pc_q    <= pc_inc;
                            state_q <= FETCH;
                        end
                    endcase
                end
                DATA_REQ: begin
                    // a store is finished once granted, a load waits for its data
                    if (if_dat.gnt) begin
                        if (op == OP_ST) begin
                            pc_q    <= pc_inc;
                            state_q <= FETCH;
                        end else begin
                            state_q <= WAIT_DATA;
                        end
                    end
                end
                WAIT_DATA: begin
                    if (if_dat.rvalid) begin
                        acc_q   <= (op == OP_ADD) ? acc_q + if_dat.rdata : if_dat.rdata;
                        pc_q    <= pc_inc;
                        state_q <= FETCH;
                    end
                end
                default: begin
                    state_q <= FETCH;
                end
            endcase
        end
    end

    // instruction register, loaded when the fetched word returns
    always_ff @(posedge clk_i) begin
        if (state_q == WAIT_INSTR && if_ins.rvalid) begin
            instr_q <= if_ins.rdata;
        end
    end

endmodule

//--- design/req_fifo.sv
/* request FIFO between a requester and a memory port
   buffers payloads in order and returns read responses straight upstream */
`timescale 1ns/100ps
`include "acc_params.svh"

module req_fifo #(
    parameter type req_t = logic,
    parameter int  DEPTH = `ACC_FIFO_DEPTH
) (
    input  logic    clk_i,
    input  logic    arst_n_i,
    mem_port_if.mem  up,
    mem_port_if.core dn
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    req_t             mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    assign full  = (count_q == CNT_W'(DEPTH));
    assign empty = (count_q == '0);

    // upstream is granted whenever there is room, downstream sees the head
    assign up.gnt     = !full;
    assign push       = up.req && !full;
    assign dn.req     = !empty;
    assign dn.payload = mem_q[rd_ptr_q];
    assign pop        = dn.req && dn.gnt;

    // responses come back in request order so they need no buffering here
    assign up.rvalid = dn.rvalid;
    assign up.rdata  = dn.rdata;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= up.payload;
        end
    end

endmodule

//--- design/mm_ram.sv
/* dual-port word RAM with a program load port
   stores to magic addresses drive the pass, fail and exit pseudo peripherals */
`timescale 1ns/100ps
`include "acc_params.svh"

module mm_ram import acc_pkg::*; (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    mem_port_if.mem                ins,
    mem_port_if.mem                dat,
    input  logic                   load_we_i,
    input  logic [`ACC_ADDR_W-1:0] load_addr_i,
    input  logic [31:0]            load_data_i,
    output logic                   tests_passed_o,
    output logic                   tests_failed_o,
    output logic                   exit_valid_o,
    output logic [31:0]            exit_value_o
);

    localparam int AW    = `ACC_ADDR_W;
    localparam int IDX_W = $clog2(`ACC_RAM_WORDS);

    logic [31:0]      ram_q [`ACC_RAM_WORDS];
    ifetch_req_t      ins_req;
    data_req_t        dat_req;
    logic             ins_in_ram;
    logic             dat_in_ram;
    logic             load_in_ram;
    logic [IDX_W-1:0] ins_idx;
    logic [IDX_W-1:0] dat_idx;
    logic [IDX_W-1:0] load_idx;
    logic             dat_wr;
    logic             dat_rd;
    logic             ins_rvalid_q;
    logic             dat_rvalid_q;
    logic [31:0]      ins_rdata_q;
    logic [31:0]      dat_rdata_q;
    logic             passed_q;
    logic             failed_q;
    logic             exit_valid_q;
    logic [31:0]      exit_value_q;

    assign ins_req = ins.payload;
    assign dat_req = dat.payload;

    // an address is in RAM when every bit above the word index is zero
    assign ins_in_ram  = (ins_req.addr[AW-1:IDX_W+2] == '0);
    assign dat_in_ram  = (dat_req.addr[AW-1:IDX_W+2] == '0);
    assign load_in_ram = (load_addr_i[AW-1:IDX_W+2] == '0);
    assign ins_idx     = ins_req.addr[IDX_W+1:2];
    assign dat_idx     = dat_req.addr[IDX_W+1:2];
    assign load_idx    = load_addr_i[IDX_W+1:2];

    // the load port takes the write side, so the data port waits during a load
    assign ins.gnt = ins.req;
    assign dat.gnt = dat.req && !load_we_i;
    assign dat_wr  = dat.gnt && dat_req.we;
    assign dat_rd  = dat.gnt && !dat_req.we;

    assign ins.rvalid = ins_rvalid_q;
    assign ins.rdata  = ins_rdata_q;
    assign dat.rvalid = dat_rvalid_q;
    assign dat.rdata  = dat_rdata_q;

    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;
    assign exit_valid_o   = exit_valid_q;
    assign exit_value_o   = exit_value_q;

    always_ff @(posedge clk_i) begin
        if (load_we_i && load_in_ram) begin
            ram_q[load_idx] <= load_data_i;
        end else if (dat_wr && dat_in_ram) begin
            ram_q[dat_idx] <= dat_req.wdata;
        end
        // read data lands one cycle after the grant, unmapped reads give zero
        if (ins.gnt) begin
            ins_rdata_q <= ins_in_ram ? ram_q[ins_idx] : '0;
        end
        if (dat_rd) begin
            dat_rdata_q <= dat_in_ram ? ram_q[dat_idx] : '0;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ins_rvalid_q <= 1'b0;
            dat_rvalid_q <= 1'b0;
            passed_q     <= 1'b0;
            failed_q     <= 1'b0;
            exit_valid_q <= 1'b0;
            exit_value_q <= '0;
        end else begin
            ins_rvalid_q <= ins.gnt;
            dat_rvalid_q <= dat_rd;
            // the peripheral flags stay set until the next reset
            if (dat_wr && dat_req.addr == `ACC_PASS_ADDR) begin
                passed_q <= 1'b1;
            end
            if (dat_wr && dat_req.addr == `ACC_FAIL_ADDR) begin
                failed_q <= 1'b1;
            end
            if (dat_wr && dat_req.addr == `ACC_EXIT_ADDR) begin
                exit_valid_q <= 1'b1;
                exit_value_q <= dat_req.wdata;
            end
        end
    end

endmodule

//--- design/acc_wrapper.sv
/* accumulator harness top level
   core, instruction and data request FIFOs, memory and exit signalling */
`timescale 1ns/100ps
`include "acc_params.svh"

module acc_wrapper import acc_pkg::*; (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   fetch_enable_i,
    input  logic                   load_we_i,
    input  logic [`ACC_ADDR_W-1:0] load_addr_i,
    input  logic [31:0]            load_data_i,
    output logic                   tests_passed_o,
    output logic                   tests_failed_o,
    output logic                   exit_valid_o,
    output logic [31:0]            exit_value_o
);

    // core side and memory side of each request path
    mem_port_if #(.req_t(ifetch_req_t)) core_if_ins ();
    mem_port_if #(.req_t(data_req_t))   core_if_dat ();
    mem_port_if #(.req_t(ifetch_req_t)) mem_if_ins ();
    mem_port_if #(.req_t(data_req_t))   mem_if_dat ();

    acc_core u_core (
        .clk_i          ( clk_i          ),
        .arst_n_i       ( arst_n_i       ),
        .fetch_enable_i ( fetch_enable_i ),
        .if_ins         ( core_if_ins    ),
        .if_dat         ( core_if_dat    )
    );

    req_fifo #(
        .req_t ( ifetch_req_t    ),
        .DEPTH ( `ACC_FIFO_DEPTH )
    ) u_ins_fifo (
        .clk_i    ( clk_i       ),
        .arst_n_i ( arst_n_i    ),
        .up       ( core_if_ins ),
        .dn       ( mem_if_ins  )
    );

    // posted stores queue here while the core goes on fetching
    req_fifo #(
        .req_t ( data_req_t      ),
        .DEPTH ( `ACC_FIFO_DEPTH )
    ) u_dat_fifo (
        .clk_i    ( clk_i       ),
        .arst_n_i ( arst_n_i    ),
        .up       ( core_if_dat ),
        .dn       ( mem_if_dat  )
    );

    mm_ram u_ram (
        .clk_i          ( clk_i          ),
        .arst_n_i       ( arst_n_i       ),
        .ins            ( mem_if_ins     ),
        .dat            ( mem_if_dat     ),
        .load_we_i      ( load_we_i      ),
        .load_addr_i    ( load_addr_i    ),
        .load_data_i    ( load_data_i    ),
        .tests_passed_o ( tests_passed_o ),
        .tests_failed_o ( tests_failed_o ),
        .exit_valid_o   ( exit_valid_o   ),
        .exit_value_o   ( exit_value_o   )
    );

endmodule

//--- tests/tb_clk_gen.sv
/* testbench clock and reset generator
   free running clock, reset held low for four cycles at start and on request */
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 20
) (
    input  logic rst_req_i,
    output logic clk_o,
    output logic arst_n_o
);

    int rst_cnt;

    initial begin
        clk_o = 1'b0;
    end

    initial begin
        arst_n_o <= 1'b0;
        rst_cnt  <= 3;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

    // reset is seen low by four rising edges and released on the fourth
    always @(posedge clk_o) begin
        if (rst_req_i) begin
            arst_n_o <= 1'b0;
            rst_cnt  <= 3;
        end else if (rst_cnt > 0) begin
            rst_cnt <= rst_cnt - 1;
        end else begin
            arst_n_o <= 1'b1;
        end
    end

endmodule

//--- tests/acc_tests.svh
/* directed tests for the accumulator harness
   each test resets the DUT, loads a program and checks the exit signalling */
`ifndef ACC_TESTS_SVH
`define ACC_TESTS_SVH

task automatic idle_after_reset();
    int errs_at_start;
    int i;
    errs_at_start = err_count;
    apply_reset();
    for (i = 0; i < LIMIT_IDLE && err_count == errs_at_start; i++) begin
        @(posedge clk);
        check_flags(1'b0, 1'b0, 1'b0);
    end
    finish_test("idle_after_reset", errs_at_start);
endtask

task automatic arith_and_memory();
    int          errs_at_start;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] c;
    logic [31:0] expected;
    errs_at_start = err_count;
    a = 16'($urandom);
    b = 16'($urandom);
    c = 16'($urandom);
    // LDI zero-extends, ADDI sign-extends
    expected = {16'h0000, a} + {16'h0000, b} + {{16{c[15]}}, c};
    prog.delete();
    prog.push_back(encode(OP_LDI, a));
    prog.push_back(encode(OP_ST, 16'h0400));
    prog.push_back(encode(OP_LDI, b));
    prog.push_back(encode(OP_ADD, 16'h0400));
    prog.push_back(encode(OP_ADDI, c));
    prog.push_back(encode(OP_ST, `ACC_EXIT_ADDR));
    prog.push_back(encode(OP_JMP, 16'(prog.size() * 4)));
    apply_reset();
    load_program();
    run_program(LIMIT_ARITH);
    check_flags(1'b0, 1'b0, 1'b1);
    if (exit_value !== expected) begin
        report_fail("exit_value_o", expected, exit_value);
    end
    finish_test("arith_and_memory", errs_at_start);
endtask

task automatic countdown_loop();
    int          errs_at_start;
    logic [15:0] n;
    logic [15:0] k;
    logic [31:0] expected;
    errs_at_start = err_count;
    n = 16'($urandom_range(16, 1));
    k = 16'($urandom_range(1000, 1));
    expected = 32'(n) * 32'(k);
    // the counter lives at 0x0420 and the remaining passes at 0x0424
    prog.delete();
    prog.push_back(encode(OP_LDI, 16'h0000));
    prog.push_back(encode(OP_ST, 16'h0420));
    prog.push_back(encode(OP_LDI, n));
    prog.push_back(encode(OP_ST, 16'h0424));
    prog.push_back(encode(OP_LD, 16'h0420));
    prog.push_back(encode(OP_ADDI, k));
    prog.push_back(encode(OP_ST, 16'h0420));
    prog.push_back(encode(OP_LD, 16'h0424));
    prog.push_back(encode(OP_ADDI, 16'hFFFF));
    prog.push_back(encode(OP_ST, 16'h0424));
    prog.push_back(encode(OP_BNZ, 16'h0010));
    prog.push_back(encode(OP_LD, 16'h0420));
    prog.push_back(encode(OP_ST, `ACC_EXIT_ADDR));
    prog.push_back(encode(OP_JMP, 16'(prog.size() * 4)));
    apply_reset();
    load_program();
    run_program(LIMIT_LOOP);
    check_flags(1'b0, 1'b0, 1'b1);
    if (exit_value !== expected) begin
        report_fail("exit_value_o", expected, exit_value);
    end
    finish_test("countdown_loop", errs_at_start);
endtask

task automatic pseudo_peripherals();
    int errs_at_start;
    errs_at_start = err_count;
    prog.delete();
    prog.push_back(encode(OP_LDI, 16'h0001));
    prog.push_back(encode(OP_ST, `ACC_PASS_ADDR));
    prog.push_back(encode(OP_JMP, 16'h0008));
    apply_reset();
    load_program();
    run_program(LIMIT_PERIPH);
    // the flag must hold while the core spins on its jump
    repeat (20) @(posedge clk);
    check_flags(1'b1, 1'b0, 1'b0);
    prog[1] = encode(OP_ST, `ACC_FAIL_ADDR);
    apply_reset();
    check_flags(1'b0, 1'b0, 1'b0);
    load_program();
    run_program(LIMIT_PERIPH);
    repeat (20) @(posedge clk);
    check_flags(1'b0, 1'b1, 1'b0);
    finish_test("pseudo_peripherals", errs_at_start);
endtask

task automatic posted_stores();
    int          errs_at_start;
    int          i;
    logic [15:0] vals [8];
    logic [31:0] expected;
    errs_at_start = err_count;
    expected = '0;
    prog.delete();
    // the low nibble keeps the eight values distinct
    for (i = 0; i < 8; i++) begin
        vals[i] = {12'($urandom), 4'(i)};
        expected = expected + {16'h0000, vals[i]};
        prog.push_back(encode(OP_LDI, vals[i]));
        prog.push_back(encode(OP_ST, 16'(16'h0600 + i * 4)));
    end
    prog.push_back(encode(OP_LD, 16'h0600));
    for (i = 1; i < 8; i++) begin
        prog.push_back(encode(OP_ADD, 16'(16'h0600 + i * 4)));
    end
    prog.push_back(encode(OP_ST, `ACC_EXIT_ADDR));
    prog.push_back(encode(OP_JMP, 16'(prog.size() * 4)));
    apply_reset();
    load_program();
    run_program(LIMIT_POSTED);
    check_flags(1'b0, 1'b0, 1'b1);
    if (exit_value !== expected) begin
        report_fail("exit_value_o", expected, exit_value);
    end
    finish_test("posted_stores", errs_at_start);
endtask

`endif

//--- tests/acc_wrapper_tb.sv
/* testbench for the accumulator harness
   loads programs through the load port, runs them and checks the exit signalling */
`timescale 1ns/100ps
`include "acc_params.svh"

module acc_wrapper_tb import acc_pkg::*; ();

    localparam int CLK_PERIOD_NS = 20;

    // cycle limits for each program run
    localparam int LIMIT_IDLE   = 50;
    localparam int LIMIT_ARITH  = 400;
    localparam int LIMIT_LOOP   = 2000;
    localparam int LIMIT_PERIPH = 300;
    localparam int LIMIT_POSTED = 800;
    localparam int WATCHDOG_CYCLES = LIMIT_IDLE + LIMIT_ARITH + LIMIT_LOOP
                                   + 2 * LIMIT_PERIPH + LIMIT_POSTED + 1000;

    logic                   clk;
    logic                   arst_n;
    logic                   rst_req;
    logic                   fetch_enable;
    logic                   load_we;
    logic [`ACC_ADDR_W-1:0] load_addr;
    logic [31:0]            load_data;
    logic                   tests_passed;
    logic                   tests_failed;
    logic                   exit_valid;
    logic [31:0]            exit_value;

    logic [31:0] prog [$];
    int          err_count  = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    tb_clk_gen #(
        .PERIOD_NS ( CLK_PERIOD_NS )
    ) u_clk_gen (
        .rst_req_i ( rst_req ),
        .clk_o     ( clk     ),
        .arst_n_o  ( arst_n  )
    );

    acc_wrapper u_dut (
        .clk_i          ( clk          ),
        .arst_n_i       ( arst_n       ),
        .fetch_enable_i ( fetch_enable ),
        .load_we_i      ( load_we      ),
        .load_addr_i    ( load_addr    ),
        .load_data_i    ( load_data    ),
        .tests_passed_o ( tests_passed ),
        .tests_failed_o ( tests_failed ),
        .exit_valid_o   ( exit_valid   ),
        .exit_value_o   ( exit_value   )
    );

    // instruction word with the opcode on top and the operand in the low half
    function automatic logic [31:0] encode(input acc_op_e op, input logic [15:0] operand);
        return {op, 12'h000, operand};
    endfunction

    task automatic report_fail(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        $display("Fail at %0d ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
        err_count++;
    endtask

    task automatic check_flags(input bit exp_pass, input bit exp_fail, input bit exp_exit);
        if (tests_passed !== exp_pass) begin
            report_fail("tests_passed_o", 32'(exp_pass), 32'(tests_passed));
        end
        if (tests_failed !== exp_fail) begin
            report_fail("tests_failed_o", 32'(exp_fail), 32'(tests_failed));
        end
        if (exit_valid !== exp_exit) begin
            report_fail("exit_valid_o", 32'(exp_exit), 32'(exit_valid));
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        fetch_enable <= 1'b0;
        rst_req      <= 1'b1;
        @(posedge clk);
        rst_req <= 1'b0;
        @(posedge clk);
        while (!arst_n) begin
            @(posedge clk);
        end
    endtask

    // the core stays idle while the program words go in, one per cycle
    task automatic load_program();
        int i;
        for (i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            load_we   <= 1'b1;
            load_addr <= 16'(i * 4);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    task automatic run_program(input int limit);
        int cycles;
        cycles = 0;
        @(posedge clk);
        fetch_enable <= 1'b1;
        while (!(exit_valid || tests_passed || tests_failed) && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!(exit_valid || tests_passed || tests_failed)) begin
            $display("program stalled: no exit, pass or fail store within %0d cycles", limit);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        if (err_count == errs_at_start) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, err_count - errs_at_start);
        end
    endtask

    `include "acc_tests.svh"

    initial begin
        void'($urandom(41992));
        rst_req      <= 1'b0;
        fetch_enable <= 1'b0;
        load_we      <= 1'b0;
        load_addr    <= '0;
        load_data    <= '0;
        idle_after_reset();
        arith_and_memory();
        countdown_loop();
        pseudo_peripherals();
        posted_stores();
        $display("tests passed %0d, failed %0d, errors %0d", pass_count, fail_count, err_count);
        if (fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("run timed out after %0d cycles before all tests finished", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+design
+incdir+tests
design/acc_pkg.sv
design/mem_port_if.sv
design/acc_core.sv
design/req_fifo.sv
design/mm_ram.sv
design/acc_wrapper.sv
tests/tb_clk_gen.sv
tests/acc_wrapper_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the accumulator harness testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing -j 0 --top-module acc_wrapper_tb -f flist.f -o acc_sim
./obj_dir/acc_sim | tee sim.log
if grep -q "^TB PASSED$" sim.log; then
    echo "simulation result: pass"
else
    echo "simulation result: fail"
    exit 1
fi
